// File: all.f
hw/bus_pkg.sv
hw/read_arbiter.sv
hw/axi_read_master.sv
hw/axi_write_master.sv
hw/mem_bus_top.sv
tests/axi_mem_model.sv
tests/mem_bus_assertions.sv
tests/tb_mem_bus.sv

// File: tests/tb_mem_bus.sv
module tb_mem_bus import bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam axi_id_t FETCH_ID = 4'd1;
  localparam axi_id_t DATA_ID  = 4'd2;
  localparam axi_id_t WRITE_ID = 4'd3;
  localparam data_t   WR_SALT  = 32'hc0de_0000;

  typedef enum logic [1:0] {OP_FETCH, OP_DATA, OP_BOTH, OP_WRITE} op_e;
  typedef struct packed {
    op_e        op;
    addr_t      addr;
    burst_len_t len;
    strb_t      strb;
  } test_t;

  // op, start address, beats minus one, write lanes
  test_t tests [8] = '{
    '{OP_FETCH, 32'h0000_0040, 8'd3, 4'hf},
    '{OP_DATA,  32'h0000_0100, 8'd0, 4'hf},
    '{OP_BOTH,  32'h0000_0200, 8'd2, 4'hf},  // fetch side reads 0x80 higher
    '{OP_WRITE, 32'h0000_0100, 8'd3, 4'hf},
    '{OP_DATA,  32'h0000_0100, 8'd3, 4'hf},
    '{OP_WRITE, 32'h0000_0300, 8'd1, 4'h5},
    '{OP_DATA,  32'h0000_0300, 8'd1, 4'hf},
    '{OP_FETCH, 32'h0000_0000, 8'd7, 4'hf}
  };

  logic    clk;
  logic    reset_i;
  logic    stall_en;
  logic    fetch_valid_i, fetch_rvalid_o, fetch_last_o;
  rd_req_t fetch_req_i;
  data_t   fetch_rdata_o;
  logic    data_valid_i, data_rvalid_o, data_last_o;
  rd_req_t data_req_i;
  data_t   data_rdata_o;
  logic    wr_valid_i, wr_beat_o, wr_done_o;
  wr_req_t wr_req_i;
  data_t   wr_data_i;
  axi_ar_t ar_o;
  axi_r_t  r_i;
  axi_aw_t aw_o;
  axi_w_t  w_o;
  axi_b_t  b_i;
  logic    arvalid_o, arready_i, rvalid_i, rready_o, awvalid_o, awready_i;
  logic    wvalid_o, wready_i, bvalid_i, bready_o;

  axi_ar_t     ar_q[$];
  axi_aw_t     aw_q[$];
  axi_w_t      w_q[$];
  logic [32:0] fetch_q[$];  // {last, data}
  logic [32:0] data_q[$];
  data_t       ref_mem [256];
  int          done_cnt;
  int          value_errs;
  int          other_errs;

  mem_bus_top #(.FETCH_ARID(FETCH_ID), .DATA_ARID(DATA_ID), .DATA_AWID(WRITE_ID)) dut_i (.*);

  axi_mem_model u_mem (
    .clk (clk), .reset_i (reset_i), .stall_i (stall_en),
    .ar_i (ar_o), .arvalid_i (arvalid_o), .arready_o (arready_i),
    .r_o (r_i), .rvalid_o (rvalid_i), .rready_i (rready_o),
    .aw_i (aw_o), .awvalid_i (awvalid_o), .awready_o (awready_i),
    .w_i (w_o), .wvalid_i (wvalid_o), .wready_o (wready_i),
    .b_o (b_i), .bvalid_o (bvalid_i), .bready_i (bready_o)
  );

  always #2 clk = ~clk;

  // handshakes sampled mid cycle once everything has settled
  always @(negedge clk) begin
    if (!reset_i) begin
      if (arvalid_o && arready_i) ar_q.push_back(ar_o);
      if (awvalid_o && awready_i) aw_q.push_back(aw_o);
      if (wvalid_o && wready_i) w_q.push_back(w_o);
      if (fetch_rvalid_o) fetch_q.push_back({fetch_last_o, fetch_rdata_o});
      if (data_rvalid_o) data_q.push_back({data_last_o, data_rdata_o});
      if (wr_done_o) done_cnt++;
    end
  end

  function automatic data_t wr_word(input addr_t addr, input int k);
    return (addr + 4 * k) ^ k ^ WR_SALT;
  endfunction

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    value_errs++;
    $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
  endtask

  task automatic fail_other(input string msg);
    other_errs++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) fail_value(name, exp, act);
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) fail_value(name, exp, act);
  endtask

  task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
    if (act !== exp) fail_value(name, exp, act);
  endtask

  task automatic check_len(input string name, input burst_len_t exp, input burst_len_t act);
    if (act !== exp) fail_value(name, exp, act);
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) fail_value(name, exp, act);
  endtask

  task automatic check_low(input string name, input logic act);
    if (act !== 1'b0) fail_value(name, 32'd0, act);
  endtask

  task automatic check_idle();
    check_low("arvalid_o", arvalid_o);
    check_low("rready_o", rready_o);
    check_low("awvalid_o", awvalid_o);
    check_low("wvalid_o", wvalid_o);
    check_low("bready_o", bready_o);
    check_low("fetch_rvalid_o", fetch_rvalid_o);
    check_low("data_rvalid_o", data_rvalid_o);
    check_low("fetch_last_o", fetch_last_o);
    check_low("data_last_o", data_last_o);
    check_low("wr_done_o", wr_done_o);
  endtask

  task automatic check_cmd(input string ch, input axi_id_t exp_id, input addr_t exp_addr,
                           input burst_len_t exp_len, input axi_ar_t cmd);
    check_id({ch, "id"}, exp_id, cmd.id);
    check_addr({ch, "addr"}, exp_addr, cmd.addr);
    check_len({ch, "len"}, exp_len, cmd.len);
    if (cmd.size !== 3'd2) fail_value({ch, "size"}, 3'd2, cmd.size);
    if (cmd.burst !== BURST_INCR) fail_value({ch, "burst"}, BURST_INCR, cmd.burst);
  endtask

  task automatic run_read(input bit is_data, input addr_t addr, input burst_len_t len);
    rd_req_t req;
    int      waited;
    bit      seen;
    req = '{addr: addr, len: len, size: 3'd2};
    @(posedge clk);
    #1;
    if (is_data) begin
      data_req_i   = req;
      data_valid_i = 1'b1;
    end else begin
      fetch_req_i   = req;
      fetch_valid_i = 1'b1;
    end
    seen = 1'b0;
    for (waited = 0; waited < (len + 1) * 40 && !seen; waited++) begin
      @(negedge clk);
      seen = is_data ? data_last_o : fetch_last_o;
    end
    if (!seen) fail_other(is_data ? "data_last_o never came" : "fetch_last_o never came");
    @(posedge clk);
    #1;
    if (is_data) data_valid_i = 1'b0;
    else fetch_valid_i = 1'b0;
  endtask

  task automatic run_write(input addr_t addr, input burst_len_t len, input strb_t strb);
    data_t      wd;
    logic [7:0] idx;
    int         k;
    int         lane;
    int         waited;
    bit         seen;
    @(posedge clk);
    #1;
    done_cnt   = 0;
    wr_req_i   = '{addr: addr, len: len, size: 3'd2, strb: strb};
    wr_data_i  = wr_word(addr, 0);
    wr_valid_i = 1'b1;
    seen = 1'b0;
    k    = 0;
    for (waited = 0; waited < (len + 1) * 40 && !seen; waited++) begin
      @(negedge clk);
      seen = wr_done_o;
      if (wr_beat_o) begin
        k++;
        @(posedge clk);
        #1;
        wr_data_i = wr_word(addr, k);  // next word after the accepting edge
      end
    end
    if (!seen) fail_other("wr_done_o never came for the write burst");
    @(posedge clk);
    #1;
    wr_valid_i = 1'b0;
    for (k = 0; k <= len; k++) begin
      wd  = wr_word(addr, k);
      idx = addr[9:2] + k[7:0];
      for (lane = 0; lane < 4; lane++) begin
        if (strb[lane]) ref_mem[idx][8*lane +: 8] = wd[8*lane +: 8];
      end
    end
  endtask

  task automatic expect_ar(input axi_id_t exp_id, input addr_t addr, input burst_len_t len);
    if (ar_q.size() == 0) begin
      fail_other("an expected AR transfer did not appear");
    end else begin
      check_cmd("ar", exp_id, addr, len, ar_q.pop_front());
    end
  endtask

  task automatic expect_beats(input bit is_data, input addr_t addr, input burst_len_t len);
    logic [32:0] beat;
    logic [7:0]  idx;
    int          k;
    int          got;
    got = is_data ? data_q.size() : fetch_q.size();
    if (got != len + 1) fail_other($sformatf("%0d beats returned, %0d asked", got, len + 1));
    for (k = 0; k < got && k <= len; k++) begin
      beat = is_data ? data_q.pop_front() : fetch_q.pop_front();
      idx  = addr[9:2] + k[7:0];
      check_data(is_data ? "data_rdata_o" : "fetch_rdata_o", ref_mem[idx], beat[31:0]);
      if (beat[32] !== (k == len)) fail_other("last flag not on exactly the final beat");
    end
    if (is_data) data_q.delete();
    else fetch_q.delete();
  endtask

  task automatic expect_write(input addr_t addr, input burst_len_t len, input strb_t strb);
    axi_w_t w;
    int     k;
    if (aw_q.size() != 1) fail_other("write burst did not show exactly one AW transfer");
    if (aw_q.size() != 0) check_cmd("aw", WRITE_ID, addr, len, aw_q.pop_front());
    if (w_q.size() != len + 1) fail_other("wrong number of W beats");
    for (k = 0; k <= len && w_q.size() != 0; k++) begin
      w = w_q.pop_front();
      check_data("wdata", wr_word(addr, k), w.data);
      check_strb("wstrb", strb, w.strb);
      if (w.last !== (k == len)) fail_other("wlast not on exactly the final W beat");
    end
    if (done_cnt != 1) fail_other("wr_done_o did not pulse exactly once");
    aw_q.delete();
    w_q.delete();
  endtask

  task automatic apply(input test_t t);
    case (t.op)
      OP_FETCH: begin
        run_read(1'b0, t.addr, t.len);
        expect_ar(FETCH_ID, t.addr, t.len);
        if (data_q.size() != 0) fail_other("data port answered a fetch request");
        expect_beats(1'b0, t.addr, t.len);
      end
      OP_DATA: begin
        run_read(1'b1, t.addr, t.len);
        expect_ar(DATA_ID, t.addr, t.len);
        if (fetch_q.size() != 0) fail_other("fetch port answered a data request");
        expect_beats(1'b1, t.addr, t.len);
      end
      OP_BOTH: begin
        fork
          run_read(1'b1, t.addr, t.len);
          run_read(1'b0, t.addr + 32'h80, t.len);
        join
        expect_ar(DATA_ID, t.addr, t.len);  // data wins the tie
        expect_ar(FETCH_ID, t.addr + 32'h80, t.len);
        expect_beats(1'b1, t.addr, t.len);
        expect_beats(1'b0, t.addr + 32'h80, t.len);
      end
      default: begin
        run_write(t.addr, t.len, t.strb);
        @(posedge clk);
        #1;
        expect_write(t.addr, t.len, t.strb);
      end
    endcase
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 200;
    foreach (tests[i]) cycles += 2 * (tests[i].len + 1) * 40;  // both passes
    repeat (cycles) @(posedge clk);
    fail_other("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int n;
    int pass;
    clk           = 1'b0;
    reset_i       = 1'b1;
    stall_en      = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_req_i   = '0;
    data_valid_i  = 1'b0;
    data_req_i    = '0;
    wr_valid_i    = 1'b0;
    wr_req_i      = '0;
    wr_data_i     = '0;
    done_cnt      = 0;
    value_errs    = 0;
    other_errs    = 0;
    for (n = 0; n < 256; n++) begin
      ref_mem[n] = (n * 4) ^ 32'h5a5a_0000;  // same fill as the memory model
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_idle();
    repeat (5) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    check_idle();
    for (pass = 0; pass < 2; pass++) begin
      stall_en = (pass == 1);  // second pass with gaps on every channel
      foreach (tests[i]) apply(tests[i]);
    end
    if (ar_q.size() + aw_q.size() + w_q.size() != 0) begin
      fail_other("AXI transfers seen that no request asked for");
    end
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/mem_bus_assertions.sv
module mem_bus_assertions import bus_pkg::*; (
  input logic    clk,
  input logic    reset_i,
  input axi_ar_t ar_i,
  input logic    arvalid_i,
  input logic    arready_i,
  input axi_aw_t aw_i,
  input logic    awvalid_i,
  input logic    awready_i,
  input axi_w_t  w_i,
  input logic    wvalid_i,
  input logic    wready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // stalled transfers keep valid and payload
  ar_held: assert property (@(posedge clk) disable iff (reset_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
    else $error("AR valid or payload changed while stalled");

  aw_held: assert property (@(posedge clk) disable iff (reset_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
    else $error("AW valid or payload changed while stalled");

  w_held: assert property (@(posedge clk) disable iff (reset_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
    else $error("W valid or payload changed while stalled");

  // wlast only rides on a live W beat
  w_last_valid: assert property (@(posedge clk) disable iff (reset_i)
    w_i.last |-> wvalid_i)
    else $error("WLAST high without WVALID");

endmodule

bind mem_bus_top mem_bus_assertions u_mem_bus_assertions (
  .clk       (clk),
  .reset_i   (reset_i),
  .ar_i      (ar_o),
  .arvalid_i (arvalid_o),
  .arready_i (arready_i),
  .aw_i      (aw_o),
  .awvalid_i (awvalid_o),
  .awready_i (awready_i),
  .w_i       (w_o),
  .wvalid_i  (wvalid_o),
  .wready_i  (wready_i)
);

// File: tests/axi_mem_model.sv
module axi_mem_model import bus_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  input  logic    stall_i,  // random ready and valid gaps when high
  input  axi_ar_t ar_i,
  input  logic    arvalid_i,
  output logic    arready_o,
  output axi_r_t  r_o,
  output logic    rvalid_o,
  input  logic    rready_i,
  input  axi_aw_t aw_i,
  input  logic    awvalid_i,
  output logic    awready_o,
  input  axi_w_t  w_i,
  input  logic    wvalid_i,
  output logic    wready_o,
  output axi_b_t  b_o,
  output logic    bvalid_o,
  input  logic    bready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  data_t      mem [256];  // 1 KB, word index is addr[9:2]
  logic [31:0] lfsr;
  logic       rd_busy;
  axi_id_t    rd_id;
  addr_t      rd_addr;
  burst_len_t rd_len;
  burst_len_t rd_cnt;
  logic       wr_busy;
  logic       b_pend;
  axi_id_t    wr_id;
  addr_t      wr_addr;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  initial begin
    int n;
    for (n = 0; n < 256; n++) begin
      mem[n] = (n * 4) ^ 32'h5a5a_0000;
    end
  end

  assign r_o = '{id: rd_id, data: mem[rd_addr[9:2]], resp: 2'b00, last: (rd_cnt == rd_len)};
  assign b_o = '{id: wr_id, resp: 2'b00};

  always @(posedge clk) begin
    logic [31:0] s;
    logic [4:0]  go;  // ar, r, aw, w, b
    int          n;
    int          lane;
    s = lfsr;
    for (n = 0; n < 5; n++) begin
      go[n] = !stall_i | s[0];
      if (stall_i) s = lfsr_step(s);  // one step per bit taken
    end
    if (reset_i) begin
      lfsr      <= 32'he37e_7600;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_busy   <= 1'b0;
      wr_busy   <= 1'b0;
      b_pend    <= 1'b0;
    end else begin
      lfsr <= s;
      // read side, one burst at a time
      arready_o <= go[0] & !rd_busy & !(arvalid_i & arready_o);
      if (arvalid_i && arready_o) begin
        rd_busy <= 1'b1;
        rd_id   <= ar_i.id;
        rd_addr <= ar_i.addr;
        rd_len  <= ar_i.len;
        rd_cnt  <= '0;
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        rd_addr  <= rd_addr + 32'd4;
        rd_cnt   <= rd_cnt + 8'd1;
        if (rd_cnt == rd_len) rd_busy <= 1'b0;
      end else if (rd_busy && go[1]) begin
        rvalid_o <= 1'b1;  // held until rready
      end
      // write side
      awready_o <= go[2] & !wr_busy & !b_pend & !(awvalid_i & awready_o);
      if (awvalid_i && awready_o) begin
        wr_busy <= 1'b1;
        wr_id   <= aw_i.id;
        wr_addr <= aw_i.addr;
      end
      wready_o <= go[3] & wr_busy & !(wvalid_i & wready_o & w_i.last);
      if (wvalid_i && wready_o && wr_busy) begin
        for (lane = 0; lane < 4; lane++) begin
          if (w_i.strb[lane]) mem[wr_addr[9:2]][8*lane +: 8] <= w_i.data[8*lane +: 8];
        end
        wr_addr <= wr_addr + 32'd4;
        if (w_i.last) begin
          wr_busy <= 1'b0;
          b_pend  <= 1'b1;
        end
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        b_pend   <= 1'b0;
      end else if (b_pend && go[4]) begin
        bvalid_o <= 1'b1;
      end
    end
  end

endmodule

// File: hw/mem_bus_top.sv
module mem_bus_top import bus_pkg::*; #(
  parameter axi_id_t FETCH_ARID = 4'd1,
  parameter axi_id_t DATA_ARID  = 4'd2,
  parameter axi_id_t DATA_AWID  = 4'd3
) (
  input  logic    clk,
  input  logic    reset_i,
  // fetch requester, icache refill side
  input  logic    fetch_valid_i,
  input  rd_req_t fetch_req_i,
  output logic    fetch_rvalid_o,
  output logic    fetch_last_o,
  output data_t   fetch_rdata_o,
  // data read requester, dcache refill side
  input  logic    data_valid_i,
  input  rd_req_t data_req_i,
  output logic    data_rvalid_o,
  output logic    data_last_o,
  output data_t   data_rdata_o,
  // data write requester, dcache writeback side
  input  logic    wr_valid_i,
  input  wr_req_t wr_req_i,
  input  data_t   wr_data_i,
  output logic    wr_beat_o,
  output logic    wr_done_o,
  // AXI4 master
  output axi_ar_t ar_o,
  output logic    arvalid_o,
  input  logic    arready_i,
  input  axi_r_t  r_i,
  input  logic    rvalid_i,
  output logic    rready_o,
  output axi_aw_t aw_o,
  output logic    awvalid_o,
  input  logic    awready_i,
  output axi_w_t  w_o,
  output logic    wvalid_o,
  input  logic    wready_i,
  input  axi_b_t  b_i,
  input  logic    bvalid_i,
  output logic    bready_o
);

  logic    rd_start;
  axi_ar_t rd_cmd;
  logic    beat_valid;
  logic    beat_last;
  data_t   beat_data;

  read_arbiter #(
    .FETCH_ARID (FETCH_ARID),
    .DATA_ARID  (DATA_ARID)
  ) u_read_arbiter (
    .clk            (clk),
    .reset_i        (reset_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_last_o   (fetch_last_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .data_valid_i   (data_valid_i),
    .data_req_i     (data_req_i),
    .data_rvalid_o  (data_rvalid_o),
    .data_last_o    (data_last_o),
    .data_rdata_o   (data_rdata_o),
    .rd_start_o     (rd_start),
    .rd_cmd_o       (rd_cmd),
    .beat_valid_i   (beat_valid),
    .beat_last_i    (beat_last),
    .beat_data_i    (beat_data)
  );

  axi_read_master u_axi_read_master (
    .clk          (clk),
    .reset_i      (reset_i),
    .rd_start_i   (rd_start),
    .rd_cmd_i     (rd_cmd),
    .ar_o         (ar_o),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .r_i          (r_i),
    .rvalid_i     (rvalid_i),
    .rready_o     (rready_o),
    .beat_valid_o (beat_valid),
    .beat_last_o  (beat_last),
    .beat_data_o  (beat_data)
  );

  axi_write_master #(
    .DATA_AWID (DATA_AWID)
  ) u_axi_write_master (
    .clk        (clk),
    .reset_i    (reset_i),
    .wr_valid_i (wr_valid_i),
    .wr_req_i   (wr_req_i),
    .wr_data_i  (wr_data_i),
    .wr_beat_o  (wr_beat_o),
    .wr_done_o  (wr_done_o),
    .aw_o       (aw_o),
    .awvalid_o  (awvalid_o),
    .awready_i  (awready_i),
    .w_o        (w_o),
    .wvalid_o   (wvalid_o),
    .wready_i   (wready_i),
    .b_i        (b_i),
    .bvalid_i   (bvalid_i),
    .bready_o   (bready_o)
  );

endmodule

// File: hw/axi_write_master.sv
module axi_write_master import bus_pkg::*; #(
  parameter axi_id_t DATA_AWID = 4'd3
) (
  input  logic    clk,
  input  logic    reset_i,
  // writeback requester
  input  logic    wr_valid_i,
  input  wr_req_t wr_req_i,
  input  data_t   wr_data_i,
  output logic    wr_beat_o,
  output logic    wr_done_o,
  // AXI4 write address channel
  output axi_aw_t aw_o,
  output logic    awvalid_o,
  input  logic    awready_i,
  // AXI4 write data channel
  output axi_w_t  w_o,
  output logic    wvalid_o,
  input  logic    wready_i,
  // AXI4 write response channel
  input  axi_b_t  b_i,
  input  logic    bvalid_i,
  output logic    bready_o
);

  wr_state_e  state;
  wr_state_e  state_next;
  wr_req_t    req_q;
  burst_len_t beat_cnt;
  logic       armed;  // wr_valid_i was low since the last burst
  logic       start;
  logic       aw_hs;
  logic       w_hs;
  logic       b_hs;
  logic       w_last;

  assign start  = (state == WR_IDLE) & wr_valid_i & armed;
  assign aw_hs  = awvalid_o & awready_i;
  assign w_hs   = wvalid_o & wready_i;
  assign b_hs   = bvalid_i & bready_o;
  assign w_last = (beat_cnt == req_q.len);

  always_comb begin
    state_next = state;
    case (state)
      WR_IDLE: begin
        if (start) state_next = WR_ADDR;
      end
      WR_ADDR: begin
        if (aw_hs) state_next = WR_DATA;
      end
      WR_DATA: begin
        if (w_hs && w_last) state_next = WR_RESP;
      end
      WR_RESP: begin
        if (b_hs) state_next = WR_IDLE;
      end
      default: state_next = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state     <= WR_IDLE;
      beat_cnt  <= '0;
      armed     <= 1'b1;
      wr_done_o <= 1'b0;
    end else begin
      state     <= state_next;
      wr_done_o <= b_hs;  // one cycle after B
      if (!wr_valid_i) begin
        armed <= 1'b1;
      end else if (start) begin
        armed <= 1'b0;  // held level must drop before the next burst
      end
      if (aw_hs) begin
        beat_cnt <= '0;
      end else if (w_hs) begin
        beat_cnt <= beat_cnt + 8'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) req_q <= wr_req_i;
  end

  assign aw_o = '{
    id:    DATA_AWID,
    addr:  req_q.addr,
    len:   req_q.len,
    size:  req_q.size,
    burst: BURST_INCR
  };
  assign awvalid_o = (state == WR_ADDR);

  // requester keeps the word up until it sees wr_beat_o
  assign w_o = '{
    data: wr_data_i,
    strb: req_q.strb,
    last: w_last & wvalid_o  // low outside a W beat
  };
  assign wvalid_o  = (state == WR_DATA);
  assign wr_beat_o = w_hs;

  // bresp and bid are taken as they come
  assign bready_o = (state == WR_RESP);

endmodule

// File: hw/axi_read_master.sv
module axi_read_master import bus_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  // granted command from the arbiter
  input  logic    rd_start_i,
  input  axi_ar_t rd_cmd_i,
  // AXI4 read address channel
  output axi_ar_t ar_o,
  output logic    arvalid_o,
  input  logic    arready_i,
  // AXI4 read data channel
  input  axi_r_t  r_i,
  input  logic    rvalid_i,
  output logic    rready_o,
  // returned beats, same cycle as the R handshake
  output logic    beat_valid_o,
  output logic    beat_last_o,
  output data_t   beat_data_o
);

  rd_state_e state;
  rd_state_e state_next;
  axi_ar_t   cmd_q;
  logic      ar_hs;
  logic      r_hs;

  assign ar_hs = arvalid_o & arready_i;
  assign r_hs  = rvalid_i & rready_o;

  always_comb begin
    state_next = state;
    case (state)
      RD_IDLE: begin
        if (rd_start_i) state_next = RD_ADDR;
      end
      RD_ADDR: begin
        if (ar_hs) state_next = RD_DATA;
      end
      RD_DATA: begin
        if (r_hs && r_i.last) state_next = RD_IDLE;  // burst done
      end
      default: state_next = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= RD_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // command held here so AR stays stable under back-pressure
  always_ff @(posedge clk) begin
    if (state == RD_IDLE && rd_start_i) begin
      cmd_q <= rd_cmd_i;
    end
  end

  assign ar_o      = cmd_q;
  assign arvalid_o = (state == RD_ADDR);
  assign rready_o  = (state == RD_DATA);  // always sink while a burst is open

  // resp is not looked at, every beat goes back
  assign beat_valid_o = r_hs;
  assign beat_last_o  = r_hs & r_i.last;
  assign beat_data_o  = r_i.data;

endmodule

// File: hw/read_arbiter.sv
module read_arbiter import bus_pkg::*; #(
  parameter axi_id_t FETCH_ARID = 4'd1,
  parameter axi_id_t DATA_ARID  = 4'd2
) (
  input  logic    clk,
  input  logic    reset_i,
  // fetch requester
  input  logic    fetch_valid_i,
  input  rd_req_t fetch_req_i,
  output logic    fetch_rvalid_o,
  output logic    fetch_last_o,
  output data_t   fetch_rdata_o,
  // data read requester
  input  logic    data_valid_i,
  input  rd_req_t data_req_i,
  output logic    data_rvalid_o,
  output logic    data_last_o,
  output data_t   data_rdata_o,
  // toward the read engine
  output logic    rd_start_o,
  output axi_ar_t rd_cmd_o,
  input  logic    beat_valid_i,
  input  logic    beat_last_i,
  input  data_t   beat_data_i
);

  logic      busy;
  rd_owner_e owner;
  logic      data_req_ok;
  logic      fetch_req_ok;
  logic      grant;
  rd_owner_e grant_owner;
  rd_req_t   grant_req;
  logic      own_data;
  logic      own_fetch;

  // a port still showing its last beat is finishing, not asking again
  assign data_req_ok  = data_valid_i & ~data_last_o;
  assign fetch_req_ok = fetch_valid_i & ~fetch_last_o;

  assign grant       = ~busy & (data_req_ok | fetch_req_ok);
  assign grant_owner = data_req_ok ? OWN_DATA : OWN_FETCH;  // memory stage first
  assign grant_req   = data_req_ok ? data_req_i : fetch_req_i;

  assign own_data  = (owner == OWN_DATA);
  assign own_fetch = (owner == OWN_FETCH);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy       <= 1'b0;
      owner      <= OWN_DATA;
      rd_start_o <= 1'b0;
    end else begin
      rd_start_o <= grant;  // one cycle pulse
      if (grant) begin
        busy  <= 1'b1;
        owner <= grant_owner;
      end else if (beat_valid_i && beat_last_i) begin
        busy <= 1'b0;  // free on the edge that registers the last beat
      end
    end
  end

  // AR command, owner id and INCR
  always_ff @(posedge clk) begin
    if (grant) begin
      rd_cmd_o <= '{
        id:    (grant_owner == OWN_DATA) ? DATA_ARID : FETCH_ARID,
        addr:  grant_req.addr,
        len:   grant_req.len,
        size:  grant_req.size,
        burst: BURST_INCR
      };
    end
  end

  // beat strobes go to the owner only
  always_ff @(posedge clk) begin
    if (reset_i) begin
      fetch_rvalid_o <= 1'b0;
      fetch_last_o   <= 1'b0;
      data_rvalid_o  <= 1'b0;
      data_last_o    <= 1'b0;
    end else begin
      fetch_rvalid_o <= beat_valid_i & own_fetch;
      fetch_last_o   <= beat_valid_i & beat_last_i & own_fetch;
      data_rvalid_o  <= beat_valid_i & own_data;
      data_last_o    <= beat_valid_i & beat_last_i & own_data;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid_i && own_fetch) fetch_rdata_o <= beat_data_i;
    if (beat_valid_i && own_data)  data_rdata_o  <= beat_data_i;
  end

endmodule

// File: hw/bus_pkg.sv
package bus_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] addr_t;       // byte address
  typedef logic [31:0] data_t;       // one bus word
  typedef logic [3:0]  strb_t;       // byte lanes of a word
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  burst_len_t;  // beats minus one
  typedef logic [2:0]  axi_size_t;

  localparam logic [1:0] BURST_INCR = 2'b01;

  // requester side
  typedef struct packed {
    addr_t      addr;
    burst_len_t len;
    axi_size_t  size;
  } rd_req_t;

  typedef struct packed {
    addr_t      addr;
    burst_len_t len;
    axi_size_t  size;
    strb_t      strb;  // same lanes on every beat
  } wr_req_t;

  // AXI4 channel payloads, valid and ready travel beside them
  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    burst_len_t len;
    axi_size_t  size;
    logic [1:0] burst;
  } axi_ar_t;

  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    burst_len_t len;
    axi_size_t  size;
    logic [1:0] burst;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t    id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t    id;
    logic [1:0] resp;
  } axi_b_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic {OWN_DATA, OWN_FETCH} rd_owner_e;

endpackage
